// ==== list.f ====
sram_pkg.sv
sram_cmd_if.sv
sram_wait_timer.sv
sram_seq.sv
sram_pins.sv
sram_ctrl_top.sv
sram_board_model.sv
tb_sram_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the SRAM controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_sram_ctrl -f list.f -o tb_sram_ctrl
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sram_ctrl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$log"; then
   echo "simulation reported failure, see $log"
   exit 1
fi

echo "simulation passed"
exit 0

// ==== sram_board_model.sv ====
/*
 * Board model of two async 256K x 16 SRAMs with byte lanes, memory starts at zero.
 * A write is stored at the rising edge of we_n. There are no timing checks.
 */
module sram_board_model
(
   input  sram_pkg::sram_addr_t      ram_a,
   input  logic                      ram_oe_n,
   input  logic                      ram_we_n,
   inout  wire sram_pkg::chip_data_t ram1_io,
   input  logic                      ram1_ce_n,
   input  logic                      ram1_ub_n,
   input  logic                      ram1_lb_n,
   inout  wire sram_pkg::chip_data_t ram2_io,
   input  logic                      ram2_ce_n,
   input  logic                      ram2_ub_n,
   input  logic                      ram2_lb_n
);

   timeunit 1ns;
   timeprecision 100ps;

   import sram_pkg::*;

   localparam int depth = 2 ** addr_w;

   logic [7:0] c1_lo [depth];
   logic [7:0] c1_hi [depth];
   logic [7:0] c2_lo [depth];
   logic [7:0] c2_hi [depth];
   logic       rd1;
   logic       rd2;

   initial
   begin
      for (int i = 0; i < depth; i++)
      begin
         c1_lo[i] = '0;
         c1_hi[i] = '0;
         c2_lo[i] = '0;
         c2_hi[i] = '0;
      end
   end

   // bytes taken at the end of the write pulse
   always @(posedge ram_we_n)
   begin
      if (!ram1_ce_n && !ram1_lb_n)
         c1_lo[ram_a] <= ram1_io[7:0];
      if (!ram1_ce_n && !ram1_ub_n)
         c1_hi[ram_a] <= ram1_io[15:8];
      if (!ram2_ce_n && !ram2_lb_n)
         c2_lo[ram_a] <= ram2_io[7:0];
      if (!ram2_ce_n && !ram2_ub_n)
         c2_hi[ram_a] <= ram2_io[15:8];
   end

   assign rd1 = !ram1_ce_n && !ram_oe_n && ram_we_n;
   assign rd2 = !ram2_ce_n && !ram_oe_n && ram_we_n;

   assign ram1_io[7:0]  = (rd1 && !ram1_lb_n) ? c1_lo[ram_a] : 8'bz;
   assign ram1_io[15:8] = (rd1 && !ram1_ub_n) ? c1_hi[ram_a] : 8'bz;
   assign ram2_io[7:0]  = (rd2 && !ram2_lb_n) ? c2_lo[ram_a] : 8'bz;
   assign ram2_io[15:8] = (rd2 && !ram2_ub_n) ? c2_hi[ram_a] : 8'bz;

endmodule

// ==== sram_cmd_if.sv ====
/*
 * Pin commands from the sequencer to the pin block.
 * All signals are active high and decoded from the sequencer state.
 */
interface sram_cmd_if;

   logic load;
   logic select;
   logic read_en;
   logic write_en;
   logic drive;
   logic capture;

   modport seq
   (
      output load, select, read_en, write_en, drive, capture
   );

   modport pins
   (
      input load, select, read_en, write_en, drive, capture
   );

endinterface

// ==== sram_ctrl_top.sv ====
/*
 * Controller for two async 256K x 16 SRAMs, single 32-bit accesses.
 * req is taken only while busy is low; done follows the accepting edge
 * by access_cycles+2 cycles. access_cycles must be at least 1.
 */
module sram_ctrl_top
#(
   parameter int unsigned access_cycles = sram_pkg::default_access_cycles
)
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      req,
   input  logic                      write,
   input  sram_pkg::sram_addr_t      addr,
   input  sram_pkg::host_data_t      wdata,
   input  sram_pkg::byte_en_t        be,
   output sram_pkg::host_data_t      rdata,
   output logic                      done,
   output logic                      busy,
   output sram_pkg::sram_addr_t      ram_a,
   output logic                      ram_oe_n,
   output logic                      ram_we_n,
   inout  wire sram_pkg::chip_data_t ram1_io,
   output logic                      ram1_ce_n,
   output logic                      ram1_ub_n,
   output logic                      ram1_lb_n,
   inout  wire sram_pkg::chip_data_t ram2_io,
   output logic                      ram2_ce_n,
   output logic                      ram2_ub_n,
   output logic                      ram2_lb_n
);

   logic start;
   logic expired;

   sram_cmd_if cmd_bus ();

   sram_seq u_seq
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (req),
      .write   (write),
      .busy    (busy),
      .done    (done),
      .start   (start),
      .expired (expired),
      .cmd     (cmd_bus.seq)
   );

   sram_wait_timer #(.access_cycles(access_cycles)) u_timer
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .start   (start),
      .expired (expired)
   );

   sram_pins u_pins
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .wdata     (wdata),
      .be        (be),
      .rdata     (rdata),
      .cmd       (cmd_bus.pins),
      .ram_a     (ram_a),
      .ram_oe_n  (ram_oe_n),
      .ram_we_n  (ram_we_n),
      .ram1_io   (ram1_io),
      .ram1_ce_n (ram1_ce_n),
      .ram1_ub_n (ram1_ub_n),
      .ram1_lb_n (ram1_lb_n),
      .ram2_io   (ram2_io),
      .ram2_ce_n (ram2_ce_n),
      .ram2_ub_n (ram2_ub_n),
      .ram2_lb_n (ram2_lb_n)
   );

endmodule

// ==== sram_pins.sv ====
/*
 * Pin block for two 256K x 16 chips on a shared address bus and shared
 * oe_n / we_n. All strobes and lanes are registered. Reads enable all
 * four byte lanes, writes use the host byte enables.
 */
module sram_pins
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  sram_pkg::sram_addr_t      addr,
   input  sram_pkg::host_data_t      wdata,
   input  sram_pkg::byte_en_t        be,
   output sram_pkg::host_data_t      rdata,
   sram_cmd_if.pins                  cmd,
   output sram_pkg::sram_addr_t      ram_a,
   output logic                      ram_oe_n,
   output logic                      ram_we_n,
   inout  wire sram_pkg::chip_data_t ram1_io,
   output logic                      ram1_ce_n,
   output logic                      ram1_ub_n,
   output logic                      ram1_lb_n,
   inout  wire sram_pkg::chip_data_t ram2_io,
   output logic                      ram2_ce_n,
   output logic                      ram2_ub_n,
   output logic                      ram2_lb_n
);

   import sram_pkg::*;

   sram_addr_t addr_q;
   host_data_t wdata_q;
   byte_en_t   be_q;
   byte_en_t   lane_n;
   logic       ce_n_q;
   logic       oe_n_q;
   logic       we_n_q;
   logic       drive_q;

   // host fields and read data
   always_ff @(posedge clk)
   begin
      if (cmd.load)
      begin
         addr_q  <= addr;
         wdata_q <= wdata;
         be_q    <= be;
      end
      if (cmd.capture)
         rdata <= {ram2_io, ram1_io};
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ce_n_q  <= 1'b1;
         oe_n_q  <= 1'b1;
         we_n_q  <= 1'b1;
         lane_n  <= '1;
         drive_q <= 1'b0;
      end
      else
      begin
         ce_n_q  <= ~cmd.select;
         oe_n_q  <= ~cmd.read_en;
         we_n_q  <= ~cmd.write_en;
         drive_q <= cmd.drive;
         // drive is only set for writes, reads open every lane
         if (cmd.select)
            lane_n <= cmd.drive ? ~be_q : '0;
         else
            lane_n <= '1;
      end
   end

   assign ram_a    = addr_q;
   assign ram_oe_n = oe_n_q;
   assign ram_we_n = we_n_q;

   assign ram1_ce_n = ce_n_q;
   assign ram1_lb_n = lane_n[0];
   assign ram1_ub_n = lane_n[1];

   assign ram2_ce_n = ce_n_q;
   assign ram2_lb_n = lane_n[2];
   assign ram2_ub_n = lane_n[3];

   assign ram1_io = drive_q ? wdata_q[15:0] : 'z;
   assign ram2_io = drive_q ? wdata_q[31:16] : 'z;

endmodule

// ==== sram_pkg.sv ====
/*
 * Shared widths and types for the dual 256K x 16 SRAM controller.
 * Chip 1 holds host bits 15..0, chip 2 holds bits 31..16.
 */
package sram_pkg;

   // one word address selects the same location in both chips
   localparam int addr_w = 18;
   localparam int host_w = 32;
   localparam int chip_w = 16;
   localparam int lanes  = 4;

   typedef logic [addr_w-1:0] sram_addr_t;
   typedef logic [host_w-1:0] host_data_t;
   typedef logic [chip_w-1:0] chip_data_t;

   // active high, bit n covers host byte n
   typedef logic [lanes-1:0] byte_en_t;

   typedef enum logic [1:0]
   {
      st_idle,
      st_access,
      st_finish
   } seq_state_t;

   // cycles that oe_n or we_n stays low, must be at least 1
   localparam int unsigned default_access_cycles = 2;

endpackage

// ==== sram_seq.sv ====
/*
 * Access sequencer. Accepts one request in idle, requests arriving
 * while busy are dropped. Commands are registered again in the pin
 * block, so each strobe shows on the pins one cycle after it is decoded.
 */
module sram_seq
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       req,
   input  logic       write,
   output logic       busy,
   output logic       done,
   output logic       start,
   input  logic       expired,
   sram_cmd_if.seq    cmd
);

   import sram_pkg::*;

   seq_state_t state;
   seq_state_t state_nxt;
   logic       accept;
   logic       is_write;

   assign accept = (state == st_idle) && req;

   always_comb
   begin
      state_nxt = state;
      case (state)
         st_idle:
         begin
            if (req)
               state_nxt = st_access;
         end
         st_access:
         begin
            if (expired)
               state_nxt = st_finish;
         end
         st_finish:
            state_nxt = st_idle;
         default:
            state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= st_idle;
         is_write <= 1'b0;
         done     <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (accept)
            is_write <= write;
         // one cycle after finish, lines up with busy falling
         done <= (state == st_finish);
      end
   end

   assign busy  = (state != st_idle);
   assign start = accept;

   assign cmd.load   = accept;
   assign cmd.select = (state != st_idle);

   // strobe drops in the last access cycle so the pins are high in finish
   assign cmd.read_en  = (state == st_access) && !is_write && !expired;
   assign cmd.write_en = (state == st_access) && is_write && !expired;

   // write data held through finish for hold time
   assign cmd.drive = is_write && (state != st_idle);

   // buses sampled on the edge that leaves access
   assign cmd.capture = (state == st_access) && expired && !is_write;

endmodule

// ==== sram_wait_timer.sv ====
/*
 * Access time counter. Loaded on start, expired is a one cycle pulse
 * access_cycles cycles after the load. access_cycles must be >= 1.
 */
module sram_wait_timer
#(
   parameter int unsigned access_cycles = sram_pkg::default_access_cycles
)
(
   input  logic clk,
   input  logic arst_n,
   input  logic start,
   output logic expired
);

   localparam int unsigned cnt_w = $clog2(access_cycles + 1);

   logic [cnt_w-1:0] count;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         count   <= '0;
         expired <= 1'b0;
      end
      else
      begin
         if (start)
            count <= cnt_w'(access_cycles);
         else if (count != '0)
            count <= count - 1'b1;
         // fires once as the count runs out
         expired <= (count == cnt_w'(1));
      end
   end

endmodule

// ==== tb_sram_ctrl.sv ====
/*
 * Testbench for sram_ctrl_top with the board model on the pins.
 * Bus float is judged from the controller's internal drive enable.
 * Chip halves are checked in the board model arrays.
 */
module tb_sram_ctrl;

   timeunit 1ns;
   timeprecision 100ps;

   import sram_pkg::*;

   localparam int unsigned n_acc = default_access_cycles;
   localparam int unsigned done_lat = n_acc + 2;
   // request, access, finish and one spare cycle
   localparam int unsigned access_len = n_acc + 4;
   localparam int unsigned watchdog_cycles = 400 * access_len;

   logic clk;
   logic arst_n;
   logic req;
   logic write;
   sram_addr_t addr;
   host_data_t wdata;
   byte_en_t be;
   host_data_t rdata;
   logic done;
   logic busy;
   sram_addr_t ram_a;
   logic ram_oe_n;
   logic ram_we_n;
   wire chip_data_t ram1_io;
   wire chip_data_t ram2_io;
   logic ram1_ce_n;
   logic ram1_ub_n;
   logic ram1_lb_n;
   logic ram2_ce_n;
   logic ram2_ub_n;
   logic ram2_lb_n;

   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int launched = 0;
   int done_count = 0;
   logic [31:0] seed = 32'h8cf9;
   host_data_t sb [sram_addr_t];
   logic in_flight;
   int unsigned lat;
   logic idle_now;

   sram_ctrl_top #(.access_cycles(n_acc)) dut (.*);

   sram_board_model board (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      #(watchdog_cycles * 10);
      $display("timeout: the run was still going after %0d clock cycles", watchdog_cycles);
      $display("TEST FAILED");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic note_error(input string msg);
      $display("error %0t: %s", $time, msg);
      errors++;
   endtask

   // edges since the accepting edge
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         in_flight <= 1'b0;
         lat       <= 0;
      end
      else if (req && !busy)
      begin
         in_flight <= 1'b1;
         lat       <= 0;
      end
      else if (in_flight)
      begin
         if (lat == done_lat)
            in_flight <= 1'b0;
         else
            lat <= lat + 1;
      end
   end

   always @(posedge done)
      done_count++;

   assign idle_now = ram1_ce_n && ram2_ce_n && ram_oe_n && ram_we_n && ram1_ub_n
      && ram1_lb_n && ram2_ub_n && ram2_lb_n && !dut.u_pins.drive_q && !done && !busy;

   a_reset: assert property (@(posedge clk) !arst_n |-> idle_now)
      else note_error("pins or handshake not idle in reset");
   a_done_slot: assert property (@(posedge clk) disable iff (!arst_n)
      done |-> in_flight && lat == done_lat)
      else note_error("done outside its latency slot");
   a_done_due: assert property (@(posedge clk) disable iff (!arst_n)
      in_flight && lat == done_lat |-> done)
      else note_error("done missing at its latency slot");
   a_done_once: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
      else note_error("done longer than one cycle");
   a_busy_span: assert property (@(posedge clk) disable iff (!arst_n)
      busy == (in_flight && lat < done_lat))
      else note_error("busy does not cover the access span");
   a_strobes: assert property (@(posedge clk) !(!ram_oe_n && !ram_we_n))
      else note_error("oe_n and we_n low together");
   a_turnaround: assert property (@(posedge clk) !ram_oe_n |-> !dut.u_pins.drive_q)
      else note_error("controller drives the buses while oe_n is low");

   // caller stands 1 ns after an edge
   task automatic launch(input logic wr, input sram_addr_t a, input host_data_t d,
                         input byte_en_t b);
      while (busy)
      begin
         @(posedge clk);
         #1;
      end
      req   = 1'b1;
      write = wr;
      addr  = a;
      wdata = d;
      be    = b;
      launched++;
      @(posedge clk);
      #1;
      req = 1'b0;
   endtask

   task automatic wait_done();
      while (!done)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic write_word(input sram_addr_t a, input host_data_t d, input byte_en_t b);
      host_data_t merged;
      merged = sb.exists(a) ? sb[a] : '0;
      for (int i = 0; i < lanes; i++)
      begin
         if (b[i])
            merged[8*i +: 8] = d[8*i +: 8];
      end
      sb[a] = merged;
      launch(1'b1, a, d, b);
      wait_done();
   endtask

   task automatic read_check(input sram_addr_t a);
      host_data_t expected;
      expected = sb.exists(a) ? sb[a] : '0;
      // reads open all lanes whatever be holds
      launch(1'b0, a, '0, '0);
      wait_done();
      assert (rdata == expected)
      else note_error($sformatf("read %05h gave %08h, expected %08h", a, rdata, expected));
   endtask

   // chip 2 holds the upper half, chip 1 the lower half
   task automatic chip_check(input sram_addr_t a);
      host_data_t stored;
      stored = {board.c2_hi[a], board.c2_lo[a], board.c1_hi[a], board.c1_lo[a]};
      assert (stored == sb[a])
      else note_error($sformatf("chips hold %08h at %05h, expected %08h", stored, a, sb[a]));
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("test %s: pass", name);
      else
      begin
         tests_failed++;
         $display("test %s: fail with %0d errors", name, errors - errors_before);
      end
   endtask

   initial
   begin
      int mark;
      sram_addr_t ra;
      arst_n = 1'b1;
      req    = 1'b0;
      write  = 1'b0;
      addr   = '0;
      wdata  = '0;
      be     = '0;

      mark = errors;
      #2;
      arst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      assert (idle_now) else note_error("pins not idle during reset");
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      assert (idle_now) else note_error("pins not idle after reset");
      finish_test("reset state", mark);

      mark = errors;
      write_word(18'h00000, 32'h0123_4567, 4'hf);
      write_word(18'h00001, 32'h89ab_cdef, 4'hf);
      write_word(18'h3ffff, 32'hfeed_5aa5, 4'hf);
      chip_check(18'h00000);
      chip_check(18'h00001);
      chip_check(18'h3ffff);
      read_check(18'h00000);
      read_check(18'h00001);
      read_check(18'h3ffff);
      finish_test("word round trip", mark);

      mark = errors;
      write_word(18'h00155, 32'ha1b2_c3d4, 4'hf);
      for (int b = 1; b < 16; b++)
      begin
         write_word(18'h00155, next_rand(), byte_en_t'(b));
         read_check(18'h00155);
      end
      read_check(18'h00200);
      read_check(18'h2abcd);
      finish_test("byte lanes", mark);

      // reads follow writes with no idle gap
      mark = errors;
      write_word(18'h00010, 32'hc0de_0010, 4'hf);
      read_check(18'h00010);
      write_word(18'h00011, 32'hc0de_0011, 4'h6);
      read_check(18'h00011);
      read_check(18'h00010);
      finish_test("fixed latency", mark);

      mark = errors;
      sb[18'h00040] = 32'h4040_4040;
      launch(1'b1, 18'h00040, 32'h4040_4040, 4'hf);
      req   = 1'b1;
      addr  = 18'h00041;
      wdata = 32'hdead_beef;
      @(posedge clk);
      #1;
      req = 1'b0;
      wait_done();
      read_check(18'h00041);
      read_check(18'h00040);
      assert (done_count == launched)
      else note_error($sformatf("%0d done pulses for %0d requests", done_count, launched));
      finish_test("ignored requests", mark);

      mark = errors;
      for (int i = 0; i < 64; i++)
      begin
         ra = sram_addr_t'(next_rand() >> 14);
         write_word(ra & 18'h3003f, next_rand(), byte_en_t'(next_rand() >> 16));
         ra = sram_addr_t'(next_rand() >> 14);
         read_check(ra & 18'h3003f);
      end
      finish_test("random traffic", mark);

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
